//--- sim/cpuStim.txt
// Word count, then program words in address order (four per line)
// Trace count, then one pair per entry: rd, expected data
0000002C
00500093 FFD00113 002081B3 40208233  // addi x1, addi x2, add, sub
0020F2B3 0020E333 0020C3B3 00112433  // and, or, xor, slt
001134B3 00109533 001155B3 40115633  // sltu, sll, srl, sra
123456B7 6786E693 FFF6C713 00309793  // lui, ori, xori, slli
40115813 00012893 0070B913 01C15993  // srai, slti, sltiu, srli
0FF6FA13 00D02423 00802A83 001A8B33  // andi, sw, lw, add using the load
00108663 00100B93 00200B93 00209663  // beq taken, two skipped, bne taken
00100C13 00200C13 00114663 00100C93  // skipped, skipped, blt taken, skipped
00200C93 0020D663 00100F13 00200F13  // skipped, bge taken, two skipped
00208463 00700D13 00115463 001D0D93  // beq not taken, addi, bge not taken, addi
00800E6F 00100E93 00500013 0000006F  // jal x28, skipped, addi x0, jal to self
0000001A
01 00000005
02 FFFFFFFD
03 00000002
04 00000008
05 00000005
06 FFFFFFFD
07 FFFFFFF8
08 00000001
09 00000000
0A 000000A0
0B 07FFFFFF
0C FFFFFFFF
0D 12345000
0D 12345678
0E EDCBA987
0F 00000028
10 FFFFFFFE
11 00000001
12 00000001
13 0000000F
14 00000078
15 12345678
16 1234567D
1A 00000007
1B 00000008
1C 000000A4

//--- build.f
hdl/rvIsaPkg.sv
hdl/pipePkg.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/memWbUnit.sv
hdl/cpuTop.sv
sim/cpuTb_properties.sv
sim/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpuTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- sim/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;
  import pipePkg::*;

  localparam int stimDepth   = 256;
  localparam int drainCycles = 40;

  logic        clk;
  logic        rstN;
  logic        run;
  logic        loadValid;
  imemLoadT    loadBeat;
  logic        loadReady;
  wbT          trace;

  logic [31:0] stim [stimDepth];
  logic        stimReady;
  int          wordCount;
  int          traceCount;
  int          seen;
  int          valueErrors;
  int          otherErrors;
  logic [15:0] lfsr;
  logic [31:0] expRd;
  logic [31:0] expData;

  cpuTop #(
    .imemWords(1024),
    .dmemWords(256)
  ) i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .run      (run),
    .loadValid(loadValid),
    .loadBeat (loadBeat),
    .loadReady(loadReady),
    .trace    (trace)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois form, taps for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] stimAt(input int idx);
    return stim[idx[7:0]];
  endfunction

  task automatic takeBits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsrStep(lfsr);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program load with random idle gaps
  //////////////////////////////////////////////////////////////////////
  task automatic loadProgram();
    int gap;
    for (int i = 0; i < wordCount; i++) begin
      takeBits(2, gap);
      loadValid <= 1'b0;
      repeat (gap) @(posedge clk);
      loadValid <= 1'b1;
      loadBeat  <= '{addr: i[9:0], data: stimAt(i + 1)};
      @(posedge clk);
      while (!loadReady) @(posedge clk);
    end
    loadValid <= 1'b0;
  endtask

  task automatic finishRun();
    $display("Errors: %0d value mismatches, %0d other", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace checker
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rstN && trace.valid) begin
      if (seen >= traceCount) begin
        $display("Unexpected trace entry past the end of the list: rd x%0d data %h",
                 trace.rd, trace.data);
        otherErrors++;
      end else begin
        expRd   = stimAt(wordCount + 2 + 2 * seen);
        expData = stimAt(wordCount + 3 + 2 * seen);
        if (trace.rd !== expRd[4:0]) begin
          $display("[FAIL] trace.rd entry %0d: got %h, expected %h", seen, trace.rd, expRd[4:0]);
          valueErrors++;
        end
        if (trace.data !== expData) begin
          $display("[FAIL] trace.data entry %0d: got %h, expected %h", seen, trace.data, expData);
          valueErrors++;
        end
      end
      seen++;
    end
  end

  initial begin
    rstN        = 1'b0;
    run         = 1'b0;
    loadValid   = 1'b0;
    loadBeat    = '0;
    seen        = 0;
    valueErrors = 0;
    otherErrors = 0;
    lfsr        = 16'd99;
    stimReady   = 1'b0;
    $readmemh("sim/cpuStim.txt", stim);
    wordCount  = int'(stim[0]);
    traceCount = int'(stimAt(wordCount + 1));
    stimReady  = 1'b1;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    loadProgram();
    run <= 1'b1;
    @(posedge clk);
    if (loadReady) begin
      $display("Load port still open after the core started running");
      otherErrors++;
    end
    while (seen < traceCount) @(posedge clk);
    // Window for a stray entry after the last one
    repeat (drainCycles) @(posedge clk);
    finishRun();
  end

  // Watchdog
  initial begin
    int limit;
    wait (stimReady);
    limit = wordCount + 40 * traceCount;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, only %0d of %0d trace entries arrived",
             limit, seen, traceCount);
    otherErrors++;
    finishRun();
  end

endmodule

//--- sim/cpuTb_properties.sv
`timescale 1ns/100ps

module cpuProperties (
  input logic              clk,
  input logic              rstN,
  input logic              run,
  input logic              loadReady,
  input logic              stall,
  input pipePkg::redirectT redirect,
  input pipePkg::wbT       trace
);

  // Load port closed while the core runs
  loadClosed: assert property (@(posedge clk) disable iff (!rstN) run |-> !loadReady)
    else $error("loadReady high while run is high");

  traceRdNonZero: assert property (@(posedge clk) disable iff (!rstN)
    trace.valid |-> trace.rd != 5'd0)
    else $error("trace valid with rd x0");

  // Bubble left in ID/EX can neither stall nor redirect
  bubbleAfterFlush: assert property (@(posedge clk) disable iff (!rstN)
    (stall || redirect.valid) |=> !(stall || redirect.valid))
    else $error("stall or redirect repeated after a flushed slot");

  traceQuietAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> !trace.valid ##1 !trace.valid)
    else $error("trace valid right after reset");

endmodule

bind cpuTop cpuProperties i_props (
  .clk      (clk),
  .rstN     (rstN),
  .run      (run),
  .loadReady(loadReady),
  .stall    (stall),
  .redirect (redirect),
  .trace    (trace)
);

//--- hdl/cpuTop.sv
`timescale 1ns/100ps

module cpuTop #(
  parameter int imemWords = 1024,
  parameter int dmemWords = 256
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              run,
  input  logic              loadValid,
  input  pipePkg::imemLoadT loadBeat,
  output logic              loadReady,
  output pipePkg::wbT       trace
);
  import pipePkg::*;

  ifIdT     ifId;
  idExT     idEx;
  exMemT    exMem;
  wbT       wb;
  redirectT redirect;
  logic     stall;

  fetchUnit #(
    .imemWords(imemWords)
  ) i_fetch (
    .clk      (clk),
    .rstN     (rstN),
    .run      (run),
    .loadValid(loadValid),
    .loadBeat (loadBeat),
    .stall    (stall),
    .redirect (redirect),
    .loadReady(loadReady),
    .ifId     (ifId)
  );

  decodeUnit i_decode (
    .clk     (clk),
    .rstN    (rstN),
    .ifId    (ifId),
    .wb      (wb),
    .redirect(redirect),
    .idEx    (idEx),
    .stall   (stall)
  );

  executeUnit i_execute (
    .clk     (clk),
    .rstN    (rstN),
    .idEx    (idEx),
    .wbFwd   (wb),
    .exMem   (exMem),
    .redirect(redirect)
  );

  memWbUnit #(
    .dmemWords(dmemWords)
  ) i_memWb (
    .clk  (clk),
    .rstN (rstN),
    .exMem(exMem),
    .wb   (wb)
  );

  // Writeback doubles as the trace port
  assign trace = wb;

endmodule

//--- hdl/memWbUnit.sv
`timescale 1ns/100ps

module memWbUnit #(
  parameter int dmemWords = 256
) (
  input  logic           clk,
  input  logic           rstN,
  input  pipePkg::exMemT exMem,
  output pipePkg::wbT    wb
);

  localparam int addrW = $clog2(dmemWords);

  logic [31:0]      dmem [dmemWords];
  logic [addrW-1:0] wordIdx;
  logic [31:0]      loadData;

  // Byte address to word index
  assign wordIdx  = exMem.result[addrW+1:2];
  assign loadData = dmem[wordIdx];

  ////////////////////////////////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < dmemWords; i++) begin
        dmem[i] <= '0;
      end
    end else if (exMem.valid && exMem.memWrite) begin
      dmem[wordIdx] <= exMem.storeData;
    end
  end

  // MEM/WB register, doubles as the trace
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wb <= '0;
    end else begin
      // Only real register writes reach the bus
      wb.valid <= exMem.valid && exMem.regWrite && exMem.rd != 5'd0;
      wb.rd    <= exMem.rd;
      if (exMem.memRead) begin
        wb.data <= loadData;
      end else if (exMem.jump) begin
        wb.data <= exMem.link;
      end else begin
        wb.data <= exMem.result;
      end
    end
  end

endmodule

//--- hdl/executeUnit.sv
`timescale 1ns/100ps

module executeUnit (
  input  logic              clk,
  input  logic              rstN,
  input  pipePkg::idExT     idEx,
  input  pipePkg::wbT       wbFwd,
  output pipePkg::exMemT    exMem,
  output pipePkg::redirectT redirect
);
  import rvIsaPkg::*;

  logic        memHitOk;
  logic [31:0] memFwdVal;
  logic [31:0] fwdA, fwdB;
  logic [31:0] opA, opB;
  logic [31:0] aluOut;
  logic        taken;

  // Loads in MEM have no data yet, the stall covers them
  assign memHitOk  = exMem.valid && exMem.regWrite && !exMem.memRead && exMem.rd != 5'd0;
  assign memFwdVal = exMem.jump ? exMem.link : exMem.result;

  // Nearer stage wins
  function automatic logic [31:0] forward(input logic [4:0] rs, input logic [31:0] regVal);
    if (rs == 5'd0) begin
      return regVal;
    end else if (memHitOk && exMem.rd == rs) begin
      return memFwdVal;
    end else if (wbFwd.valid && wbFwd.rd == rs) begin
      return wbFwd.data;
    end
    return regVal;
  endfunction

  always_comb begin
    fwdA = forward(idEx.rs1, idEx.rs1Val);
    fwdB = forward(idEx.rs2, idEx.rs2Val);
  end

  assign opA = idEx.selA ? idEx.pc : fwdA;
  assign opB = idEx.selB ? idEx.imm : fwdB;

  ////////////////////////////////////////////////////////////////////
  // ALU and branch compare
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    case (idEx.aluOp)
      aluAdd:   aluOut = opA + opB;
      aluSub:   aluOut = opA - opB;
      aluAnd:   aluOut = opA & opB;
      aluOr:    aluOut = opA | opB;
      aluXor:   aluOut = opA ^ opB;
      aluSlt:   aluOut = {31'd0, $signed(opA) < $signed(opB)};
      aluSltu:  aluOut = {31'd0, opA < opB};
      aluSll:   aluOut = opA << opB[4:0];
      aluSrl:   aluOut = opA >> opB[4:0];
      aluSra:   aluOut = $unsigned($signed(opA) >>> opB[4:0]);
      aluPassB: aluOut = opB;
      default:  aluOut = opA + opB;
    endcase
  end

  always_comb begin
    case (idEx.brKind)
      brEq:    taken = fwdA == fwdB;
      brNe:    taken = fwdA != fwdB;
      brLt:    taken = $signed(fwdA) < $signed(fwdB);
      brGe:    taken = $signed(fwdA) >= $signed(fwdB);
      default: taken = 1'b0;
    endcase
  end

  // Target is pc + imm from the ALU
  assign redirect = '{valid: idEx.valid && (taken || idEx.jump), target: aluOut};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem <= '0;
    end else begin
      exMem.valid     <= idEx.valid;
      exMem.result    <= aluOut;
      exMem.storeData <= fwdB;
      exMem.rd        <= idEx.rd;
      exMem.memRead   <= idEx.valid && idEx.memRead;
      exMem.memWrite  <= idEx.valid && idEx.memWrite;
      exMem.regWrite  <= idEx.valid && idEx.regWrite;
      exMem.jump      <= idEx.jump;
      exMem.link      <= idEx.pc + 32'd4;
    end
  end

endmodule

//--- hdl/decodeUnit.sv
`timescale 1ns/100ps

module decodeUnit (
  input  logic              clk,
  input  logic              rstN,
  input  pipePkg::ifIdT     ifId,
  input  pipePkg::wbT       wb,
  input  pipePkg::redirectT redirect,
  output pipePkg::idExT     idEx,
  output logic              stall
);
  import rvIsaPkg::*;

  logic [31:0] instr;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic        funct7b30;
  logic [31:0] immI, immS, immB, immU, immJ;
  logic [31:0] imm;
  aluOpE       aluOp;
  brKindE      brKind;
  logic        selA, selB;
  logic        memRead, memWrite, jump, regWrite;
  logic        usesRs1, usesRs2;
  logic [31:0] regs [32];
  logic [31:0] rs1Val, rs2Val;

  function automatic aluOpE aluFromF3(input logic [2:0] f3, input logic alt);
    case (f3)
      f3AddSub: return alt ? aluSub : aluAdd;
      f3Sll:    return aluSll;
      f3Slt:    return aluSlt;
      f3Sltu:   return aluSltu;
      f3Xor:    return aluXor;
      f3Sr:     return alt ? aluSra : aluSrl;
      f3Or:     return aluOr;
      default:  return aluAnd;
    endcase
  endfunction

  // Bubbles decode as a plain nop
  assign instr     = ifId.valid ? ifId.instr : nopWord;
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign funct7b30 = instr[30];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'd0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    aluOp    = aluAdd;
    brKind   = brNone;
    imm      = immI;
    selA     = 1'b0;
    selB     = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    jump     = 1'b0;
    regWrite = 1'b0;
    usesRs1  = 1'b1;
    usesRs2  = 1'b0;
    case (instr[6:0])
      opcOp: begin
        aluOp    = aluFromF3(funct3, funct7b30);
        regWrite = 1'b1;
        usesRs2  = 1'b1;
      end
      opcOpImm: begin
        // bit 30 is only an op select for shifts right
        aluOp    = aluFromF3(funct3, funct7b30 && funct3 == f3Sr);
        selB     = 1'b1;
        regWrite = 1'b1;
      end
      opcLui: begin
        aluOp    = aluPassB;
        imm      = immU;
        selB     = 1'b1;
        regWrite = 1'b1;
        usesRs1  = 1'b0;
      end
      opcLoad: begin
        selB     = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
      end
      opcStore: begin
        imm      = immS;
        selB     = 1'b1;
        memWrite = 1'b1;
        usesRs2  = 1'b1;
      end
      opcBranch: begin
        // ALU forms the target, comparison is separate
        imm     = immB;
        selA    = 1'b1;
        selB    = 1'b1;
        usesRs2 = 1'b1;
        case (funct3)
          f3Beq:   brKind = brEq;
          f3Bne:   brKind = brNe;
          f3Blt:   brKind = brLt;
          f3Bge:   brKind = brGe;
          default: brKind = brNone;
        endcase
      end
      opcJal: begin
        imm      = immJ;
        selA     = 1'b1;
        selB     = 1'b1;
        jump     = 1'b1;
        regWrite = 1'b1;
        usesRs1  = 1'b0;
      end
      default: begin
        usesRs1 = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Register file, write-first
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1Val = (rs1 == 5'd0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2Val = (rs2 == 5'd0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

  // Load in EX feeding the instruction in ID
  assign stall = ifId.valid && idEx.valid && idEx.memRead && idEx.rd != 5'd0 &&
                 ((usesRs1 && rs1 == idEx.rd) || (usesRs2 && rs2 == idEx.rd));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      idEx <= '0;
    end else if (redirect.valid || stall || !ifId.valid) begin
      idEx <= '0;
    end else begin
      idEx.valid    <= 1'b1;
      idEx.pc       <= ifId.pc;
      idEx.rs1Val   <= rs1Val;
      idEx.rs2Val   <= rs2Val;
      idEx.imm      <= imm;
      idEx.rs1      <= usesRs1 ? rs1 : 5'd0;
      idEx.rs2      <= usesRs2 ? rs2 : 5'd0;
      idEx.rd       <= rd;
      idEx.aluOp    <= aluOp;
      idEx.selA     <= selA;
      idEx.selB     <= selB;
      idEx.memRead  <= memRead;
      idEx.memWrite <= memWrite;
      idEx.brKind   <= brKind;
      idEx.jump     <= jump;
      idEx.regWrite <= regWrite;
    end
  end

endmodule

//--- hdl/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit #(
  parameter int imemWords = 1024
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              run,
  input  logic              loadValid,
  input  pipePkg::imemLoadT loadBeat,
  input  logic              stall,
  input  pipePkg::redirectT redirect,
  output logic              loadReady,
  output pipePkg::ifIdT     ifId
);
  import rvIsaPkg::*;

  localparam int addrW = $clog2(imemWords);

  logic [31:0] imem [imemWords];
  logic [31:0] pc;
  logic [31:0] instr;

  // Port is open only while the core is stopped
  assign loadReady = !run;

  always_ff @(posedge clk) begin
    if (loadValid && loadReady) begin
      imem[loadBeat.addr[addrW-1:0]] <= loadBeat.data;
    end
  end

  // Word read at the current pc
  assign instr = imem[pc[addrW+1:2]];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (run) begin
      if (redirect.valid) begin
        pc <= redirect.target;
      end else if (!stall) begin
        pc <= pc + 32'd4;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN || !run || redirect.valid) begin
      ifId.valid <= 1'b0;
      ifId.pc    <= '0;
      ifId.instr <= nopWord;
    end else if (!stall) begin
      ifId.valid <= 1'b1;
      ifId.pc    <= pc;
      ifId.instr <= instr;
    end
  end

endmodule

//--- hdl/pipePkg.sv
package pipePkg;

  ////////////////////////////////////////////////////////////////////
  // External load port and redirect
  ////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [9:0]  addr;
    logic [31:0] data;
  } imemLoadT;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirectT;

  ////////////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } ifIdT;

  typedef struct packed {
    logic              valid;
    logic [31:0]       pc;
    logic [31:0]       rs1Val;
    logic [31:0]       rs2Val;
    logic [31:0]       imm;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    rvIsaPkg::aluOpE   aluOp;
    // A takes pc, B takes the immediate
    logic              selA;
    logic              selB;
    logic              memRead;
    logic              memWrite;
    rvIsaPkg::brKindE  brKind;
    logic              jump;
    logic              regWrite;
  } idExT;

  typedef struct packed {
    logic        valid;
    logic [31:0] result;
    logic [31:0] storeData;
    logic [4:0]  rd;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic        jump;
    logic [31:0] link;
  } exMemT;

  // Writeback bus, also the trace
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wbT;

endpackage

//--- hdl/rvIsaPkg.sv
package rvIsaPkg;

  ////////////////////////////////////////////////////////////////////
  // Major opcodes of the supported subset
  ////////////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    opcOp     = 7'b0110011,
    opcOpImm  = 7'b0010011,
    opcLui    = 7'b0110111,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcBranch = 7'b1100011,
    opcJal    = 7'b1101111
  } opcodeE;

  // funct3 for register and immediate ALU ops
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Sr     = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3Beq = 3'b000;
  localparam logic [2:0] f3Bne = 3'b001;
  localparam logic [2:0] f3Blt = 3'b100;
  localparam logic [2:0] f3Bge = 3'b101;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra,
    aluPassB
  } aluOpE;

  // Branch condition resolved in execute
  typedef enum logic [2:0] {
    brNone, brEq, brNe, brLt, brGe
  } brKindE;

  // addi x0,x0,0
  localparam logic [31:0] nopWord = 32'h0000_0013;

endpackage
